/* rtl/forth_mem_pkg.sv */
//----------------------------------------------------------------------------
// forth_mem_pkg
// Widths and counts of the stack-machine data memory: a 32K x 32 word store
// built from four 16K x 16 RAM banks, also seen as 128K bytes by the debug port.
//----------------------------------------------------------------------------
`default_nettype none

package forth_mem_pkg;

    // word side, as seen by the CPU
    localparam int DATA_W      = 32;   // bits per memory word
    localparam int LANES       = 4;    // byte lanes per word
    localparam int BYTE_W      = 8;    // bits per byte lane

    // one RAM bank
    localparam int HALF_W      = 16;   // bank data width, half a word
    localparam int NIBBLES     = 4;    // write mask bits per bank
    localparam int BANK_DEPTH  = 16384;   // words per bank

    // address widths
    // word address: bit 14 picks the bank pair, 13:0 go to the banks
    localparam int WORD_ADDR_W = 15;
    localparam int BANK_ADDR_W = 14;
    // byte address: bits 1:0 give the lane, 16:2 the word
    localparam int BYTE_ADDR_W = 17;

endpackage : forth_mem_pkg

`default_nettype wire

/* rtl/spram_bank.sv */
//----------------------------------------------------------------------------
// spram_bank
// Behavioural 16K x 16 single-port RAM cell with chip select, nibble write
// mask and a registered read port that holds between reads.
//----------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module spram_bank (
    input  logic                                clk,
    input  logic [forth_mem_pkg::BANK_ADDR_W-1:0] addr,
    input  logic [forth_mem_pkg::HALF_W-1:0]      wdata,
    input  logic [forth_mem_pkg::NIBBLES-1:0]     mask,   // one enable per nibble
    input  logic                                we,
    input  logic                                cs,
    output logic [forth_mem_pkg::HALF_W-1:0]      rdata
);

    import forth_mem_pkg::*;

    logic [HALF_W-1:0] mem [0:BANK_DEPTH-1];   // cell array, contents undefined

    // write port, nibble granular
    always_ff @(posedge clk) begin
        if (cs && we) begin
            for (int n = 0; n < NIBBLES; n++) begin
                if (mask[n]) begin
                    mem[addr][n*(HALF_W/NIBBLES) +: HALF_W/NIBBLES] <=
                        wdata[n*(HALF_W/NIBBLES) +: HALF_W/NIBBLES];
                end
            end
        end
    end

    // output register of the cell
    // loads only on a selected read and keeps its value otherwise
    always_ff @(posedge clk) begin
        if (cs && !we) begin
            rdata <= mem[addr];   // read-before-write is not needed, single port
        end
    end

endmodule : spram_bank

`default_nettype wire

/* rtl/spram_word.sv */
//----------------------------------------------------------------------------
// spram_word
// 32K x 32 word memory from two pairs of 16K x 16 banks. Expands the byte
// mask into bank nibble masks and steers the read data by a registered
// bank-pair select.
//----------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module spram_word (
    input  logic                                  clk,
    input  logic                                  arst_n,
    input  logic                                  we,
    input  logic [forth_mem_pkg::LANES-1:0]       bmsk,    // bit 0 is bits 7:0
    input  logic [forth_mem_pkg::WORD_ADDR_W-1:0] addr,
    input  logic [forth_mem_pkg::DATA_W-1:0]      wdata,
    output logic [forth_mem_pkg::DATA_W-1:0]      rdata
);

    import forth_mem_pkg::*;

    // bank outputs, indexed [pair][half], half 1 is bits 31:16
    logic [HALF_W-1:0]  bank_rdata [2][2];
    logic [NIBBLES-1:0] half_mask  [2];
    logic               pair;
    logic               pair_q;      // pair of the last read

    assign pair = addr[WORD_ADDR_W-1];

    // each byte enable covers two nibbles of its half
    always_comb begin
        for (int h = 0; h < 2; h++) begin
            half_mask[h] = {bmsk[2*h+1], bmsk[2*h+1], bmsk[2*h], bmsk[2*h]};
        end
    end

    genvar p, h;
    generate
        for (p = 0; p < 2; p++) begin : g_pair
            for (h = 0; h < 2; h++) begin : g_half
                spram_bank i_bank (
                    .clk   (clk),
                    .addr  (addr[BANK_ADDR_W-1:0]),
                    .wdata (wdata[h*HALF_W +: HALF_W]),
                    .mask  (half_mask[h]),
                    .we    (we),
                    .cs    (pair == p[0]),   // pair chosen by addr bit 14
                    .rdata (bank_rdata[p][h])
                );
            end
        end
    endgenerate

    // the bank output registers only change on reads, so the mux must
    // follow the address of the last read, not the current request
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pair_q <= 1'b0;
        end else if (!we) begin
            pair_q <= pair;
        end
    end

    always_comb begin
        rdata = {bank_rdata[pair_q][1], bank_rdata[pair_q][0]};
    end

endmodule : spram_word

`default_nettype wire

/* rtl/debug_byte_bridge.sv */
//----------------------------------------------------------------------------
// debug_byte_bridge
// Selects the CPU word port or the debug byte port as the memory request.
// Byte requests become one-hot masked word requests; the read byte is taken
// from the word by the lane of the last debug read.
//----------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module debug_byte_bridge (
    input  logic                                  clk,
    input  logic                                  arst_n,

    // CPU word port
    input  logic                                  cpu_we,
    input  logic [forth_mem_pkg::LANES-1:0]       cpu_bmsk,
    input  logic [forth_mem_pkg::WORD_ADDR_W-1:0] cpu_addr,
    input  logic [forth_mem_pkg::DATA_W-1:0]      cpu_wdata,
    output logic [forth_mem_pkg::DATA_W-1:0]      cpu_rdata,

    // debug byte port
    input  logic                                  dbg_en,
    input  logic                                  dbg_we,
    input  logic [forth_mem_pkg::BYTE_ADDR_W-1:0] dbg_addr,
    input  logic [forth_mem_pkg::BYTE_W-1:0]      dbg_wdata,
    output logic [forth_mem_pkg::BYTE_W-1:0]      dbg_rdata,

    // word request to the memory
    output logic                                  mem_we,
    output logic [forth_mem_pkg::LANES-1:0]       mem_bmsk,
    output logic [forth_mem_pkg::WORD_ADDR_W-1:0] mem_addr,
    output logic [forth_mem_pkg::DATA_W-1:0]      mem_wdata,
    input  logic [forth_mem_pkg::DATA_W-1:0]      mem_rdata
);

    import forth_mem_pkg::*;

    logic [1:0] dbg_lane;
    logic [1:0] lane_q;       // lane of the last debug read

    assign dbg_lane = dbg_addr[1:0];

    // request mux, debug port wins while enabled
    always_comb begin
        if (dbg_en) begin
            mem_we    = dbg_we;
            mem_bmsk  = LANES'(1) << dbg_lane;   // one lane only
            mem_addr  = dbg_addr[BYTE_ADDR_W-1:2];
            mem_wdata = {LANES{dbg_wdata}};      // same byte on every lane
        end else begin
            mem_we    = cpu_we;
            mem_bmsk  = cpu_bmsk;
            mem_addr  = cpu_addr;
            mem_wdata = cpu_wdata;
        end
    end

    // read data comes one cycle after the request, so keep the lane
    // until then; writes leave it alone so the byte holds like the word
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lane_q <= 2'd0;
        end else if (dbg_en && !dbg_we) begin
            lane_q <= dbg_lane;
        end
    end

    assign dbg_rdata = mem_rdata[lane_q*BYTE_W +: BYTE_W];
    assign cpu_rdata = mem_rdata;   // CPU always sees the full word

endmodule : debug_byte_bridge

`default_nettype wire

/* rtl/forth_mem.sv */
//----------------------------------------------------------------------------
// forth_mem
// Data memory of the stack-machine CPU: a 32K x 32 word port for the CPU
// and a 128K byte debug port that takes over while enabled.
//----------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module forth_mem (
    input  logic                                  clk,
    input  logic                                  arst_n,

    // CPU word port
    input  logic                                  cpu_we,
    input  logic [forth_mem_pkg::LANES-1:0]       cpu_bmsk,
    input  logic [forth_mem_pkg::WORD_ADDR_W-1:0] cpu_addr,
    input  logic [forth_mem_pkg::DATA_W-1:0]      cpu_wdata,
    output logic [forth_mem_pkg::DATA_W-1:0]      cpu_rdata,

    // debug byte port
    input  logic                                  dbg_en,
    input  logic                                  dbg_we,
    input  logic [forth_mem_pkg::BYTE_ADDR_W-1:0] dbg_addr,
    input  logic [forth_mem_pkg::BYTE_W-1:0]      dbg_wdata,
    output logic [forth_mem_pkg::BYTE_W-1:0]      dbg_rdata
);

    import forth_mem_pkg::*;

    // word request between bridge and memory
    logic                   mem_we;
    logic [LANES-1:0]       mem_bmsk;
    logic [WORD_ADDR_W-1:0] mem_addr;
    logic [DATA_W-1:0]      mem_wdata;
    logic [DATA_W-1:0]      mem_rdata;

    debug_byte_bridge i_bridge (
        .clk       (clk),
        .arst_n    (arst_n),
        .cpu_we    (cpu_we),
        .cpu_bmsk  (cpu_bmsk),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .cpu_rdata (cpu_rdata),
        .dbg_en    (dbg_en),
        .dbg_we    (dbg_we),
        .dbg_addr  (dbg_addr),
        .dbg_wdata (dbg_wdata),
        .dbg_rdata (dbg_rdata),
        .mem_we    (mem_we),
        .mem_bmsk  (mem_bmsk),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

    spram_word i_spram_word (
        .clk    (clk),
        .arst_n (arst_n),
        .we     (mem_we),
        .bmsk   (mem_bmsk),
        .addr   (mem_addr),
        .wdata  (mem_wdata),
        .rdata  (mem_rdata)
    );

endmodule : forth_mem

`default_nettype wire

/* verification/tb_forth_mem.sv */
//----------------------------------------------------------------------------
// tb_forth_mem
// Directed testbench for the stack-machine data memory. Drives the CPU word
// port and the debug byte port and checks read data against a word model.
//----------------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module tb_forth_mem;

    import forth_mem_pkg::*;

    localparam int          CLK_PERIOD     = 100;
    localparam int          RESET_CYCLES   = 16;
    localparam int          TIMEOUT_CYCLES = 6000;
    localparam int          RANDOM_CYCLES  = 400;
    localparam logic [31:0] SEED           = 32'h02cd_ec0b;
    localparam logic [WORD_ADDR_W-1:0] WIN_BASE = 15'h3ff8;   // window across both pairs
    localparam int          WIN_WORDS      = 16;

    logic                   clk;
    logic                   arst_n;
    logic                   cpu_we;
    logic [LANES-1:0]       cpu_bmsk;
    logic [WORD_ADDR_W-1:0] cpu_addr;
    logic [DATA_W-1:0]      cpu_wdata;
    logic [DATA_W-1:0]      cpu_rdata;
    logic                   dbg_en;
    logic                   dbg_we;
    logic [BYTE_ADDR_W-1:0] dbg_addr;
    logic [BYTE_W-1:0]      dbg_wdata;
    logic [BYTE_W-1:0]      dbg_rdata;

    logic [DATA_W-1:0] ref_mem [int];   // word model keyed by word address
    int err_count    = 0;
    int check_count  = 0;
    int tests_run    = 0;
    int tests_failed = 0;
    int cycle_count  = 0;

    forth_mem i_forth_mem (
        .clk       (clk),
        .arst_n    (arst_n),
        .cpu_we    (cpu_we),
        .cpu_bmsk  (cpu_bmsk),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .cpu_rdata (cpu_rdata),
        .dbg_en    (dbg_en),
        .dbg_we    (dbg_we),
        .dbg_addr  (dbg_addr),
        .dbg_wdata (dbg_wdata),
        .dbg_rdata (dbg_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("run stopped after %0d cycles, tests did not complete", cycle_count);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // lane l of the new word is taken where bmsk[l] is set
    function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_word,
                                                     input logic [DATA_W-1:0] new_word,
                                                     input logic [LANES-1:0] bmsk);
        logic [DATA_W-1:0] res;
        res = old_word;
        for (int l = 0; l < LANES; l++) begin
            if (bmsk[l]) begin
                res[l*BYTE_W +: BYTE_W] = new_word[l*BYTE_W +: BYTE_W];
            end
        end
        return res;
    endfunction

    function automatic logic [DATA_W-1:0] model_word(input logic [WORD_ADDR_W-1:0] addr);
        if (ref_mem.exists(int'(addr))) begin
            return ref_mem[int'(addr)];
        end
        return 'x;   // never written
    endfunction

    task automatic check_value(input string name, input logic [DATA_W-1:0] exp,
                               input logic [DATA_W-1:0] got);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("Fail at %0d ns: %s expected %h, got %h", $time, name, exp, got);
        end
    endtask

    // all access tasks start and end on a falling edge
    task automatic cpu_write(input logic [WORD_ADDR_W-1:0] addr, input logic [LANES-1:0] bmsk,
                             input logic [DATA_W-1:0] data);
        dbg_en    = 1'b0;
        cpu_we    = 1'b1;
        cpu_bmsk  = bmsk;
        cpu_addr  = addr;
        cpu_wdata = data;
        @(negedge clk);
        ref_mem[int'(addr)] = merge_bytes(model_word(addr), data, bmsk);
    endtask

    task automatic cpu_read_check(input logic [WORD_ADDR_W-1:0] addr);
        dbg_en   = 1'b0;
        cpu_we   = 1'b0;
        cpu_addr = addr;
        @(negedge clk);
        check_value("cpu_rdata", model_word(addr), cpu_rdata);
    endtask

    task automatic dbg_write(input logic [BYTE_ADDR_W-1:0] baddr, input logic [BYTE_W-1:0] data);
        logic [WORD_ADDR_W-1:0] waddr;
        logic [DATA_W-1:0]      word;
        waddr     = baddr[BYTE_ADDR_W-1:2];
        dbg_en    = 1'b1;
        dbg_we    = 1'b1;
        dbg_addr  = baddr;
        dbg_wdata = data;
        @(negedge clk);
        // only the addressed lane takes the byte
        word = model_word(waddr);
        word[baddr[1:0]*BYTE_W +: BYTE_W] = data;
        ref_mem[int'(waddr)] = word;
    endtask

    task automatic dbg_read_check(input logic [BYTE_ADDR_W-1:0] baddr);
        logic [DATA_W-1:0] word;
        word     = model_word(baddr[BYTE_ADDR_W-1:2]);
        dbg_en   = 1'b1;
        dbg_we   = 1'b0;
        dbg_addr = baddr;
        @(negedge clk);
        check_value("dbg_rdata", 32'(word[baddr[1:0]*BYTE_W +: BYTE_W]), 32'(dbg_rdata));
        check_value("cpu_rdata", word, cpu_rdata);
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (err_count == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, err_count - errs_before);
        end
    endtask

    task automatic test_full_words();
        logic [WORD_ADDR_W-1:0] addrs [6] = '{15'h0123, 15'h4123, 15'h0000,
                                             15'h3fff, 15'h4000, 15'h7fff};
        int errs;
        errs = err_count;
        foreach (addrs[i]) cpu_write(addrs[i], 4'hf, $urandom);
        foreach (addrs[i]) cpu_read_check(addrs[i]);
        report_test("full words in both bank pairs", errs);
    endtask

    task automatic test_byte_masks();
        int errs;
        errs = err_count;
        for (int m = 0; m < 16; m++) begin
            cpu_write(15'h0040, 4'hf, 32'h8765_4321);   // known base word
            cpu_write(15'h0040, LANES'(m), $urandom);
            cpu_read_check(15'h0040);
            cpu_write(15'h4040, 4'hf, 32'h1234_5678);
            cpu_write(15'h4040, LANES'(m), $urandom);
            cpu_read_check(15'h4040);
        end
        report_test("byte masks", errs);
    endtask

    task automatic test_debug_write();
        int errs;
        errs = err_count;
        cpu_write(15'h0200, 4'hf, 32'hcafe_f00d);
        cpu_write(15'h4200, 4'hf, 32'h1357_9bdf);
        for (int l = 0; l < LANES; l++) begin
            dbg_write({15'h0200, 2'(l)}, 8'h10 + 8'(l));
            cpu_read_check(15'h0200);
            dbg_write({15'h4200, 2'(3 - l)}, $urandom);
            cpu_read_check(15'h4200);
        end
        report_test("debug byte write", errs);
    endtask

    task automatic test_debug_read();
        int errs;
        errs = err_count;
        cpu_write(15'h4321, 4'hf, 32'hdead_beef);
        cpu_write(15'h0321, 4'hf, 32'h0bad_c0de);
        for (int l = 0; l < LANES; l++) begin
            dbg_read_check({15'h4321, 2'(l)});
        end
        // both read ports hold through writes elsewhere
        cpu_write(15'h4322, 4'hf, $urandom);
        check_value("dbg_rdata", 32'hde, 32'(dbg_rdata));
        check_value("cpu_rdata", 32'hdead_beef, cpu_rdata);
        dbg_write({15'h0322, 2'd1}, 8'h5a);
        check_value("dbg_rdata", 32'hde, 32'(dbg_rdata));
        cpu_write(15'h0321, 4'h3, $urandom);
        check_value("dbg_rdata", 32'hde, 32'(dbg_rdata));
        check_value("cpu_rdata", 32'hdead_beef, cpu_rdata);
        report_test("debug byte read", errs);
    endtask

    task automatic test_debug_priority();
        int errs;
        errs = err_count;
        cpu_write(15'h0500, 4'hf, 32'h0f0f_0f0f);
        cpu_write(15'h4500, 4'hf, 32'hf0f0_f0f0);
        // CPU write presented during a debug read and a debug write
        cpu_we    = 1'b1;
        cpu_bmsk  = 4'hf;
        cpu_addr  = 15'h0500;
        cpu_wdata = 32'hffff_ffff;
        dbg_read_check({15'h4500, 2'd2});
        cpu_addr = 15'h4500;
        dbg_write({15'h0600, 2'd0}, 8'h77);
        cpu_read_check(15'h0500);
        cpu_read_check(15'h4500);
        cpu_read_check(15'h0600);
        report_test("debug port priority", errs);
    endtask

    task automatic test_random_mix();
        logic [WORD_ADDR_W-1:0] waddr;
        logic [1:0]             lane;
        int errs;
        errs = err_count;
        for (int w = 0; w < WIN_WORDS; w++) begin
            cpu_write(WIN_BASE + WORD_ADDR_W'(w), 4'hf, $urandom);
        end
        for (int c = 0; c < RANDOM_CYCLES; c++) begin
            waddr = WIN_BASE + WORD_ADDR_W'($urandom_range(0, WIN_WORDS - 1));
            lane  = 2'($urandom);
            // CPU inputs carry junk writes while the debug port is active
            cpu_we    = 1'b1;
            cpu_bmsk  = 4'(($urandom));
            cpu_addr  = WIN_BASE + WORD_ADDR_W'($urandom_range(0, WIN_WORDS - 1));
            cpu_wdata = $urandom;
            case ($urandom_range(0, 3))
                0: cpu_write(waddr, 4'($urandom), $urandom);
                1: cpu_read_check(waddr);
                2: dbg_write({waddr, lane}, 8'($urandom));
                default: dbg_read_check({waddr, lane});
            endcase
        end
        report_test("random mix", errs);
    endtask

    initial begin
        void'($urandom(SEED));
        arst_n    = 1'b0;
        cpu_we    = 1'b0;
        cpu_bmsk  = '0;
        cpu_addr  = '0;
        cpu_wdata = '0;
        dbg_en    = 1'b0;
        dbg_we    = 1'b0;
        dbg_addr  = '0;
        dbg_wdata = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);

        test_full_words();
        test_byte_masks();
        test_debug_write();
        test_debug_read();
        test_debug_priority();
        test_random_mix();

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, check_count, err_count);
        if (err_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule : tb_forth_mem

`default_nettype wire

/* forth_mem.f */
rtl/forth_mem_pkg.sv
rtl/spram_bank.sv
rtl/spram_word.sv
rtl/debug_byte_bridge.sv
rtl/forth_mem.sv
verification/tb_forth_mem.sv

/* Bender.yml */
package:
  name: forth_mem

sources:
  # package first, then the blocks bottom up
  - rtl/forth_mem_pkg.sv
  - rtl/spram_bank.sv
  - rtl/spram_word.sv
  - rtl/debug_byte_bridge.sv
  - rtl/forth_mem.sv

  - target: test
    files:
      - verification/tb_forth_mem.sv
